/* common/mem_pkg.sv */
package mem_pkg;

    // address and data width
    localparam int XLEN = 32;

    // byte lanes per word
    localparam int STRB_W = XLEN / 8;

    // low address bits below the word index
    localparam int WORD_LSB = 2;

    // csr address width, bit 3 picks cfg or addr
    localparam int CSR_AW = 4;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'd0,
        PMP_TOR   = 2'd1,
        PMP_NA4   = 2'd2,
        PMP_NAPOT = 2'd3
    } pmp_mode_e;

    // one pmpcfg byte
    typedef struct packed {
        logic      l;
        logic [1:0] rsv;
        pmp_mode_e a;
        logic      x;
        logic      w;
        logic      r;
    } pmp_cfg_t;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } prv_e;

    typedef enum logic [1:0] {
        BAD_NONE = 2'd0,
        BAD_PMP  = 2'd1,
        BAD_BUS  = 2'd2
    } bad_e;

    // data port command
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic              write;
        logic [STRB_W-1:0] strb;
        logic [XLEN-1:0]   wdata;
    } core_req_t;

    // response back to the core
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
        bad_e            bad;
    } core_rsp_t;

endpackage

/* pmp/pmp_csr.sv */
module pmp_csr #(
    parameter int PMP_ENTRIES = 4
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              csr_we,
    input  logic [mem_pkg::CSR_AW-1:0]        csr_addr,
    input  logic [mem_pkg::XLEN-1:0]          csr_wdata,
    output logic [mem_pkg::XLEN-1:0]          csr_rdata,

    output mem_pkg::pmp_cfg_t                 pmp_cfg  [PMP_ENTRIES],
    output logic [mem_pkg::XLEN-1:0]          pmp_addr [PMP_ENTRIES]
);

logic [PMP_ENTRIES-1:0] tor_lock;
mem_pkg::pmp_cfg_t      cfg_wr;

// pmpaddr i is frozen by a locked TOR entry i+1
always_comb begin
    tor_lock = '0;
    for (int i = 1; i < PMP_ENTRIES; i++) begin
        tor_lock[i-1] = pmp_cfg[i].l && (pmp_cfg[i].a == mem_pkg::PMP_TOR);
    end
end

// reserved bits always read zero
always_comb begin
    cfg_wr     = mem_pkg::pmp_cfg_t'(csr_wdata[7:0]);
    cfg_wr.rsv = 2'b00;
end

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            pmp_cfg[i]  <= '0;
            pmp_addr[i] <= '0;
        end
    end else if (csr_we) begin
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            if (csr_addr[2:0] == 3'(i) && !pmp_cfg[i].l) begin
                if (!csr_addr[3]) begin
                    pmp_cfg[i] <= cfg_wr;
                end else if (!tor_lock[i]) begin
                    pmp_addr[i] <= csr_wdata;
                end
            end
        end
    end
end

// unimplemented entries read as zero
always_comb begin
    csr_rdata = '0;
    for (int i = 0; i < PMP_ENTRIES; i++) begin
        if (csr_addr[2:0] == 3'(i)) begin
            if (csr_addr[3]) begin
                csr_rdata = pmp_addr[i];
            end else begin
                csr_rdata = {{(mem_pkg::XLEN - 8){1'b0}}, pmp_cfg[i]};
            end
        end
    end
end

endmodule

/* pmp/pmp_check.sv */
module pmp_check #(
    parameter int PMP_ENTRIES = 4,
    parameter bit FETCH       = 1'b0
) (
    input  mem_pkg::pmp_cfg_t        pmp_cfg  [PMP_ENTRIES],
    input  logic [mem_pkg::XLEN-1:0] pmp_addr [PMP_ENTRIES],
    input  mem_pkg::prv_e            prv,
    input  logic [mem_pkg::XLEN-1:0] addr,
    input  logic                     write,
    output logic                     allow
);

logic [mem_pkg::XLEN-1:0] word;
logic [PMP_ENTRIES-1:0]   match;
logic                     hit;
mem_pkg::pmp_cfg_t        hit_cfg;
logic                     perm;

// word index, same scale as pmpaddr
assign word = {{mem_pkg::WORD_LSB{1'b0}}, addr[mem_pkg::XLEN-1:mem_pkg::WORD_LSB]};

for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_entry
    logic [mem_pkg::XLEN-1:0] lo;
    logic [mem_pkg::XLEN-1:0] care;

    // TOR base is the previous entry, or zero for entry 0
    if (i == 0) begin : g_first
        assign lo = '0;
    end else begin : g_rest
        assign lo = pmp_addr[i-1];
    end

    // trailing ones plus the bit above them are don't-care
    assign care = ~(pmp_addr[i] ^ (pmp_addr[i] + 1'b1));

    always_comb begin
        case (pmp_cfg[i].a)
            mem_pkg::PMP_TOR: begin
                match[i] = (word >= lo) && (word < pmp_addr[i]);
            end
            mem_pkg::PMP_NA4: begin
                match[i] = (word == pmp_addr[i]);
            end
            mem_pkg::PMP_NAPOT: begin
                match[i] = ((word ^ pmp_addr[i]) & care) == '0;
            end
            default: begin
                match[i] = 1'b0;
            end
        endcase
    end
end

// lowest index wins, so scan downwards
always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
        if (match[i]) begin
            hit     = 1'b1;
            hit_cfg = pmp_cfg[i];
        end
    end
end

always_comb begin
    if (FETCH) begin
        perm = hit_cfg.x;
    end else if (write) begin
        perm = hit_cfg.w;
    end else begin
        perm = hit_cfg.r;
    end
end

// M mode only bound by locked entries
always_comb begin
    if (!hit) begin
        allow = (prv == mem_pkg::PRV_M);
    end else if (prv == mem_pkg::PRV_M) begin
        allow = !hit_cfg.l || perm;
    end else begin
        allow = perm;
    end
end

endmodule

/* hdl/mem_arb.sv */
module mem_arb #(
    parameter int  SRAM_DEPTH = 1024,
    localparam int AW         = $clog2(SRAM_DEPTH)
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          i_req,
    input  logic [mem_pkg::XLEN-1:0]      i_addr,
    input  logic                          i_allow,
    output logic                          i_busy,

    input  logic                          d_req,
    input  mem_pkg::core_req_t            d_cmd,
    input  logic                          d_allow,

    output mem_pkg::core_rsp_t            i_rsp,
    output mem_pkg::core_rsp_t            d_rsp,

    output logic                          sram_cs,
    output logic                          sram_we,
    output logic [AW-1:0]                 sram_addr,
    output logic [mem_pkg::STRB_W-1:0]    sram_strb,
    output logic [mem_pkg::XLEN-1:0]      sram_wdata,
    input  logic [mem_pkg::XLEN-1:0]      sram_rdata
);

logic                     i_acc;
logic                     acc;
logic [mem_pkg::XLEN-1:0] sel_addr;
logic                     sel_write;
logic                     sel_allow;
logic                     in_range;
mem_pkg::bad_e            bad;

logic                     rsp_i_vld;
logic                     rsp_d_vld;
mem_pkg::bad_e            rsp_bad;
logic                     rsp_rd;
logic [mem_pkg::XLEN-1:0] rsp_rdata;

// data port always wins
assign i_busy = d_req;
assign i_acc  = i_req && !d_req;
assign acc    = d_req || i_acc;

always_comb begin
    if (d_req) begin
        sel_addr  = d_cmd.addr;
        sel_write = d_cmd.write;
        sel_allow = d_allow;
    end else begin
        sel_addr  = i_addr;
        sel_write = 1'b0;
        sel_allow = i_allow;
    end
end

assign in_range = {{mem_pkg::WORD_LSB{1'b0}}, sel_addr[mem_pkg::XLEN-1:mem_pkg::WORD_LSB]}
                < mem_pkg::XLEN'(SRAM_DEPTH);

// pmp takes precedence over the range check
always_comb begin
    if (!sel_allow) begin
        bad = mem_pkg::BAD_PMP;
    end else if (!in_range) begin
        bad = mem_pkg::BAD_BUS;
    end else begin
        bad = mem_pkg::BAD_NONE;
    end
end

assign sram_cs    = acc && (bad == mem_pkg::BAD_NONE);
assign sram_we    = sram_cs && sel_write;
assign sram_addr  = sel_addr[mem_pkg::WORD_LSB +: AW];
assign sram_strb  = d_cmd.strb;
assign sram_wdata = d_cmd.wdata;

always_ff @(posedge clk) begin
    if (rst) begin
        rsp_i_vld <= 1'b0;
        rsp_d_vld <= 1'b0;
    end else begin
        rsp_i_vld <= i_acc;
        rsp_d_vld <= d_req;
    end
end

always_ff @(posedge clk) begin
    if (acc) begin
        rsp_bad <= bad;
        rsp_rd  <= !sel_write;
    end
end

// faults and writes return zero
assign rsp_rdata = (rsp_rd && rsp_bad == mem_pkg::BAD_NONE) ? sram_rdata : '0;

assign i_rsp = '{valid: rsp_i_vld, rdata: rsp_rdata, bad: rsp_bad};
assign d_rsp = '{valid: rsp_d_vld, rdata: rsp_rdata, bad: rsp_bad};

endmodule

/* hdl/sram.sv */
module sram #(
    parameter int  SRAM_DEPTH = 1024,
    localparam int AW         = $clog2(SRAM_DEPTH)
) (
    input  logic                       clk,
    input  logic                       cs,
    input  logic                       we,
    input  logic [AW-1:0]              addr,
    input  logic [mem_pkg::STRB_W-1:0] strb,
    input  logic [mem_pkg::XLEN-1:0]   wdata,
    output logic [mem_pkg::XLEN-1:0]   rdata
);

logic [mem_pkg::XLEN-1:0] mem [SRAM_DEPTH];

// byte lanes written independently
always_ff @(posedge clk) begin
    if (cs) begin
        if (we) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (strb[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end else begin
            rdata <= mem[addr];
        end
    end
end

endmodule

/* hdl/mem_wrap.sv */
module mem_wrap #(
    parameter int PMP_ENTRIES = 4,
    parameter int SRAM_DEPTH  = 1024
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        csr_we,
    input  logic [mem_pkg::CSR_AW-1:0]  csr_addr,
    input  logic [mem_pkg::XLEN-1:0]    csr_wdata,
    output logic [mem_pkg::XLEN-1:0]    csr_rdata,

    input  mem_pkg::prv_e               prv,

    input  logic                        i_req,
    input  logic [mem_pkg::XLEN-1:0]    i_addr,
    output logic                        i_busy,
    output mem_pkg::core_rsp_t          i_rsp,

    input  logic                        d_req,
    input  mem_pkg::core_req_t          d_cmd,
    output mem_pkg::core_rsp_t          d_rsp
);

localparam int AW = $clog2(SRAM_DEPTH);

mem_pkg::pmp_cfg_t        pmp_cfg  [PMP_ENTRIES];
logic [mem_pkg::XLEN-1:0] pmp_addr [PMP_ENTRIES];

logic                       i_allow;
logic                       d_allow;

logic                       sram_cs;
logic                       sram_we;
logic [AW-1:0]              sram_addr;
logic [mem_pkg::STRB_W-1:0] sram_strb;
logic [mem_pkg::XLEN-1:0]   sram_wdata;
logic [mem_pkg::XLEN-1:0]   sram_rdata;

pmp_csr #(.PMP_ENTRIES(PMP_ENTRIES)) u_pmp_csr (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .csr_we    ( csr_we    ),
    .csr_addr  ( csr_addr  ),
    .csr_wdata ( csr_wdata ),
    .csr_rdata ( csr_rdata ),
    .pmp_cfg   ( pmp_cfg   ),
    .pmp_addr  ( pmp_addr  )
);

// fetch side checks x
pmp_check #(.PMP_ENTRIES(PMP_ENTRIES), .FETCH(1'b1)) u_ipmp (
    .pmp_cfg  ( pmp_cfg  ),
    .pmp_addr ( pmp_addr ),
    .prv      ( prv      ),
    .addr     ( i_addr   ),
    .write    ( 1'b0     ),
    .allow    ( i_allow  )
);

pmp_check #(.PMP_ENTRIES(PMP_ENTRIES), .FETCH(1'b0)) u_dpmp (
    .pmp_cfg  ( pmp_cfg     ),
    .pmp_addr ( pmp_addr    ),
    .prv      ( prv         ),
    .addr     ( d_cmd.addr  ),
    .write    ( d_cmd.write ),
    .allow    ( d_allow     )
);

mem_arb #(.SRAM_DEPTH(SRAM_DEPTH)) u_mem_arb (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .i_req      ( i_req      ),
    .i_addr     ( i_addr     ),
    .i_allow    ( i_allow    ),
    .i_busy     ( i_busy     ),
    .d_req      ( d_req      ),
    .d_cmd      ( d_cmd      ),
    .d_allow    ( d_allow    ),
    .i_rsp      ( i_rsp      ),
    .d_rsp      ( d_rsp      ),
    .sram_cs    ( sram_cs    ),
    .sram_we    ( sram_we    ),
    .sram_addr  ( sram_addr  ),
    .sram_strb  ( sram_strb  ),
    .sram_wdata ( sram_wdata ),
    .sram_rdata ( sram_rdata )
);

sram #(.SRAM_DEPTH(SRAM_DEPTH)) u_sram (
    .clk   ( clk        ),
    .cs    ( sram_cs    ),
    .we    ( sram_we    ),
    .addr  ( sram_addr  ),
    .strb  ( sram_strb  ),
    .wdata ( sram_wdata ),
    .rdata ( sram_rdata )
);

endmodule

/* bench/mem_wrap_asserts.sv */
module mem_wrap_asserts (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_req,
    input  logic               i_busy,
    input  logic               d_req,
    input  mem_pkg::core_rsp_t i_rsp,
    input  mem_pkg::core_rsp_t d_rsp
);

// one response cycle per accepted access
a_d_rsp: assert property (@(posedge clk) disable iff (rst) d_req |=> d_rsp.valid)
    else $error("data response missing after acceptance");

a_i_rsp: assert property (@(posedge clk) disable iff (rst) (i_req && !i_busy) |=> i_rsp.valid)
    else $error("fetch response missing after acceptance");

// a fetch held off by the data port is not taken
a_held: assert property (@(posedge clk) disable iff (rst) (i_req && i_busy) |=> !i_rsp.valid)
    else $error("fetch answered while busy");

a_reset: assert property (@(posedge clk) $past(rst) |-> (!i_rsp.valid && !d_rsp.valid))
    else $error("response valid right after reset");

endmodule

bind mem_arb mem_wrap_asserts u_arb_asserts (
    .clk    ( clk    ),
    .rst    ( rst    ),
    .i_req  ( i_req  ),
    .i_busy ( i_busy ),
    .d_req  ( d_req  ),
    .i_rsp  ( i_rsp  ),
    .d_rsp  ( d_rsp  )
);

/* bench/mem_wrap_tb.sv */
module mem_wrap_tb;

localparam int PMP_N    = 4;
localparam int DEPTH    = 1024;
localparam int AW       = $clog2(DEPTH);
localparam int N_RAND   = 80;
localparam int N_ROUNDS = 4;
localparam int N_OPS    = 30;
localparam int N_HOLD   = 6;
localparam int N_FAR    = 20;
localparam int TEST_CYCLES = 33 + (21 + N_RAND) + N_ROUNDS * (26 + N_OPS) + (19 + N_RAND)
                           + (3 + 3 * N_HOLD) + (N_FAR + 1);
localparam int MAX_CYCLES = TEST_CYCLES + 100;

logic               clk = 1'b0;
logic               rst;
logic               csr_we;
logic [3:0]         csr_addr;
logic [31:0]        csr_wdata;
logic [31:0]        csr_rdata;
mem_pkg::prv_e      prv;
logic               i_req;
logic [31:0]        i_addr;
logic               i_busy;
mem_pkg::core_rsp_t i_rsp;
logic               d_req;
mem_pkg::core_req_t d_cmd;
mem_pkg::core_rsp_t d_rsp;

// reference model state
mem_pkg::pmp_cfg_t cfg_m [PMP_N];
logic [31:0]       addr_m [PMP_N];
logic [31:0]       mem_model [DEPTH];

logic [31:0] lfsr = 32'h45f21a5e;
logic        busy_seen;
logic        i_pending;
int          cycles = 0;
int          checks = 0;
int          errors = 0;
int          tests = 0;
int          err_start;

mem_wrap #(.PMP_ENTRIES(PMP_N), .SRAM_DEPTH(DEPTH)) uut (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .csr_we    ( csr_we    ),
    .csr_addr  ( csr_addr  ),
    .csr_wdata ( csr_wdata ),
    .csr_rdata ( csr_rdata ),
    .prv       ( prv       ),
    .i_req     ( i_req     ),
    .i_addr    ( i_addr    ),
    .i_busy    ( i_busy    ),
    .i_rsp     ( i_rsp     ),
    .d_req     ( d_req     ),
    .d_cmd     ( d_cmd     ),
    .d_rsp     ( d_rsp     )
);

always #10 clk = ~clk;

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end
end

// taps 32 22 2 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
        lfsr = lfsr_step(lfsr);
        r = {r[30:0], lfsr[0]};
    end
    return r;
endfunction

// 16 word window at the bottom of the SRAM
function automatic logic [31:0] win_addr();
    return rand_bits(4) << 2;
endfunction

function automatic logic [31:0] far_addr();
    return (32'(DEPTH) + rand_bits(20)) << 2;
endfunction

function automatic logic tor_locked(int j);
    if (j >= PMP_N) begin
        return 1'b0;
    end
    return cfg_m[j].l && (cfg_m[j].a == mem_pkg::PMP_TOR);
endfunction

task automatic csr_model_write(logic [3:0] a, logic [31:0] d);
    int i;
    i = int'(a[2:0]);
    if (i < PMP_N && !cfg_m[i].l) begin
        if (!a[3]) begin
            cfg_m[i] = mem_pkg::pmp_cfg_t'(d[7:0] & 8'h9f);
        end else if (!tor_locked(i + 1)) begin
            addr_m[i] = d;
        end
    end
endtask

function automatic logic [31:0] csr_model_read(logic [3:0] a);
    int i;
    i = int'(a[2:0]);
    if (i >= PMP_N) begin
        return '0;
    end
    return a[3] ? addr_m[i] : {24'b0, cfg_m[i]};
endfunction

function automatic logic entry_covers(int i, logic [31:0] w);
    logic [31:0] lo;
    int          t;
    case (cfg_m[i].a)
        mem_pkg::PMP_TOR: begin
            lo = (i == 0) ? '0 : addr_m[i - 1];
            return (w >= lo) && (w < addr_m[i]);
        end
        mem_pkg::PMP_NA4: begin
            return w == addr_m[i];
        end
        mem_pkg::PMP_NAPOT: begin
            // region of 2^(t+1) words, t = trailing ones
            t = 0;
            while (t < 32 && addr_m[i][t]) begin
                t++;
            end
            if (t >= 31) begin
                return 1'b1;
            end
            return (w >> (t + 1)) == (addr_m[i] >> (t + 1));
        end
        default: begin
            return 1'b0;
        end
    endcase
endfunction

function automatic logic pmp_allows(logic [31:0] addr, logic write, logic fetch,
                                    mem_pkg::prv_e p);
    logic need;
    for (int i = 0; i < PMP_N; i++) begin
        if (entry_covers(i, addr >> 2)) begin
            need = fetch ? cfg_m[i].x : (write ? cfg_m[i].w : cfg_m[i].r);
            if (p == mem_pkg::PRV_M) begin
                return !cfg_m[i].l || need;
            end
            return need;
        end
    end
    return p == mem_pkg::PRV_M;
endfunction

function automatic mem_pkg::core_rsp_t model_access(logic [31:0] addr, logic write,
        logic fetch, logic [3:0] strb, logic [31:0] wdata);
    mem_pkg::core_rsp_t r;
    logic [AW-1:0]      wi;
    r.valid = 1'b1;
    r.rdata = '0;
    wi = addr[AW+1:2];
    if (!pmp_allows(addr, write, fetch, prv)) begin
        r.bad = mem_pkg::BAD_PMP;
    end else if ((addr >> 2) >= 32'(DEPTH)) begin
        r.bad = mem_pkg::BAD_BUS;
    end else begin
        r.bad = mem_pkg::BAD_NONE;
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    mem_model[wi][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else begin
            r.rdata = mem_model[wi];
        end
    end
    return r;
endfunction

task automatic check_rsp(mem_pkg::core_rsp_t got, mem_pkg::core_rsp_t exp, string what);
    checks++;
    if (got.valid !== exp.valid
            || (exp.valid && (got.rdata !== exp.rdata || got.bad !== exp.bad))) begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected valid %0b rdata %h bad %0d", $time, what,
                 exp.valid, exp.rdata, exp.bad);
        $display("    got valid %0b rdata %h bad %0d", got.valid, got.rdata, got.bad);
    end
endtask

task automatic check_csr(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
    end
endtask

task automatic check_bit(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected %0b got %0b", $time, what, exp, got);
    end
endtask

// inputs are stable at the rising edge, responses at the falling edge
task automatic clock_step();
    mem_pkg::core_rsp_t i_exp;
    mem_pkg::core_rsp_t d_exp;
    @(posedge clk);
    busy_seen = i_busy;
    i_exp = '0;
    d_exp = '0;
    if (d_req) begin
        d_exp = model_access(d_cmd.addr, d_cmd.write, 1'b0, d_cmd.strb, d_cmd.wdata);
    end else if (i_req) begin
        i_exp = model_access(i_addr, 1'b0, 1'b1, 4'h0, 32'h0);
    end
    if (csr_we) begin
        csr_model_write(csr_addr, csr_wdata);
    end
    @(negedge clk);
    check_rsp(d_rsp, d_exp, "data response");
    check_rsp(i_rsp, i_exp, "fetch response");
endtask

task automatic apply_reset();
    rst = 1'b1;
    csr_we = 1'b0;
    i_req = 1'b0;
    d_req = 1'b0;
    i_pending = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < PMP_N; i++) begin
        cfg_m[i] = '0;
        addr_m[i] = '0;
    end
endtask

task automatic csr_write(logic [3:0] a, logic [31:0] d);
    csr_we = 1'b1;
    csr_addr = a;
    csr_wdata = d;
    clock_step();
    csr_we = 1'b0;
endtask

task automatic csr_read_check(logic [3:0] a);
    csr_addr = a;
    clock_step();
    check_csr(csr_rdata, csr_model_read(a), "csr readback");
endtask

task automatic data_op(logic [31:0] addr, logic write, logic [3:0] strb, logic [31:0] wdata);
    d_req = 1'b1;
    d_cmd.addr = addr;
    d_cmd.write = write;
    d_cmd.strb = strb;
    d_cmd.wdata = wdata;
    clock_step();
    d_req = 1'b0;
endtask

task automatic fetch_op(logic [31:0] addr);
    i_req = 1'b1;
    i_addr = addr;
    clock_step();
    i_req = 1'b0;
endtask

// a fetch left waiting behind a data access stays on the port
task automatic random_cycle();
    if (!i_pending) begin
        i_req = 1'(rand_bits(1));
        i_addr = win_addr();
    end
    d_req = 1'(rand_bits(1));
    d_cmd.addr = win_addr();
    d_cmd.write = 1'(rand_bits(1));
    d_cmd.strb = 4'(rand_bits(4));
    d_cmd.wdata = rand_bits(32);
    clock_step();
    i_pending = i_req && d_req;
endtask

task automatic drain();
    d_req = 1'b0;
    if (i_pending) begin
        clock_step();
    end
    i_req = 1'b0;
    i_pending = 1'b0;
endtask

task automatic end_test(string name);
    tests++;
    if (errors == err_start) begin
        $display("test %0d %s: ok", tests, name);
    end else begin
        $display("test %0d %s: %0d errors", tests, name, errors - err_start);
    end
    err_start = errors;
endtask

initial begin
    csr_we = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    prv = mem_pkg::PRV_M;
    i_req = 1'b0;
    i_addr = '0;
    d_req = 1'b0;
    d_cmd = '0;
    err_start = 0;
    apply_reset();

    for (int e = 0; e < PMP_N; e++) begin
        csr_write(4'(e), rand_bits(7));
        csr_write(4'(8 + e), rand_bits(32));
    end
    // entry 2 locked TOR, freezes pmpaddr 1 and 2
    csr_write(4'd2, 32'h89);
    csr_write(4'd2, rand_bits(8));
    csr_write(4'd10, rand_bits(32));
    csr_write(4'd9, rand_bits(32));
    csr_write(4'd8, rand_bits(32));
    csr_write(4'd1, rand_bits(7));
    csr_write(4'd6, rand_bits(8));
    for (int a = 0; a < 16; a++) begin
        csr_read_check(4'(a));
    end
    end_test("csr access and locks");

    apply_reset();
    for (int w = 0; w < 16; w++) begin
        data_op(32'(w) << 2, 1'b1, 4'hf, rand_bits(32));
    end
    repeat (N_RAND) random_cycle();
    drain();
    end_test("machine mode, pmp off");

    for (int n = 0; n < N_ROUNDS; n++) begin
        for (int e = 0; e < PMP_N; e++) begin
            csr_write(4'(8 + e), rand_bits(4));
            csr_write(4'(e), rand_bits(5));
        end
        prv = mem_pkg::PRV_U;
        repeat (N_OPS) random_cycle();
        drain();
        // sweep the window to see what the denied writes left
        prv = mem_pkg::PRV_M;
        for (int w = 0; w < 16; w++) begin
            data_op(32'(w) << 2, 1'b0, 4'h0, 32'h0);
        end
    end
    end_test("user mode regions");

    apply_reset();
    csr_write(4'd8, 32'd3);
    csr_write(4'd9, 32'd9);
    csr_write(4'd10, 32'd14);
    csr_write(4'd11, rand_bits(4));
    csr_write(4'd0, 32'h90);
    csr_write(4'd1, 32'h18);
    csr_write(4'd2, 32'h8c);
    csr_write(4'd3, 32'h80 | rand_bits(5));
    data_op(32'd12, 1'b0, 4'h0, 32'h0);
    data_op(32'd12, 1'b1, 4'hf, rand_bits(32));
    fetch_op(32'd12);
    data_op(32'd48, 1'b0, 4'h0, 32'h0);
    fetch_op(32'd48);
    data_op(32'd36, 1'b0, 4'h0, 32'h0);
    repeat (N_RAND) random_cycle();
    drain();
    end_test("machine mode locks");

    apply_reset();
    for (int n = 0; n < N_HOLD; n++) begin
        i_req = 1'b1;
        i_addr = win_addr();
        d_req = 1'b1;
        d_cmd.addr = win_addr();
        d_cmd.write = 1'(rand_bits(1));
        d_cmd.strb = 4'(rand_bits(4));
        d_cmd.wdata = rand_bits(32);
        clock_step();
        check_bit(busy_seen, 1'b1, "i_busy with data request");
        d_req = 1'b0;
        clock_step();
        check_bit(busy_seen, 1'b0, "i_busy without data request");
        i_req = 1'b0;
        clock_step();
    end
    end_test("simultaneous requests");

    for (int n = 0; n < N_FAR; n++) begin
        if (rand_bits(1) != 0) begin
            fetch_op(far_addr());
        end else begin
            data_op(far_addr(), 1'(rand_bits(1)), 4'hf, rand_bits(32));
        end
    end
    end_test("out of range");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

/* build.f */
common/mem_pkg.sv
pmp/pmp_csr.sv
pmp/pmp_check.sv
hdl/mem_arb.sv
hdl/sram.sv
hdl/mem_wrap.sv
bench/mem_wrap_asserts.sv
bench/mem_wrap_tb.sv

/* Makefile */
TOP = mem_wrap_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
